// File: event_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module event_arbiter
  import kbd_event_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        full,
  key_event_if.grant  chan0,
  key_event_if.grant  chan1,
  output logic        push,
  output kbd_event_t  push_event
);

  logic [NUM_CHANNELS-1:0] req_vec;
  logic                    any_req;
  logic                    pick;
  logic                    last;
  logic                    acking;

  // --------------------
  // Round-robin pick
  // --------------------

  assign req_vec = {chan1.req, chan0.req};
  assign any_req = |req_vec;

  // Favour the channel not served last
  always_comb begin
    if (req_vec[~last]) begin
      pick = ~last;
    end else begin
      pick = last;
    end
  end

  // Only one event in flight, so no new push while acking
  assign push = !acking && any_req && !full;

  // Tag with source channel
  assign push_event.port     = pick;
  assign push_event.released = pick ? chan1.released : chan0.released;
  assign push_event.extended = pick ? chan1.extended : chan0.extended;
  assign push_event.code     = pick ? chan1.code : chan0.code;

  // --------------------
  // Handshake control
  // --------------------

  // last doubles as the channel being acknowledged
  always_ff @(posedge clk) begin
    if (rst) begin
      acking <= 1'b0;
      // Channel 0 gets the first turn
      last   <= 1'b1;
    end else begin
      if (push) begin
        acking <= 1'b1;
        last   <= pick;
      end else if (acking && !req_vec[last]) begin
        // Phase 4, req seen low
        acking <= 1'b0;
      end
    end
  end

  // Phase 2, one cycle after the push
  assign chan0.ack = acking && (last == 1'b0);
  assign chan1.ack = acking && (last == 1'b1);

endmodule

`default_nettype wire

// File: event_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module event_fifo
  import kbd_event_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  kbd_event_t push_event,
  input  logic       evt_ready,
  output logic       full,
  output logic       evt_valid,
  output kbd_event_t evt_out
);

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  kbd_event_t  mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        wr_en;
  logic        rd_en;

  // --------------------
  // Status
  // --------------------

  // Extra MSB tells a wrapped writer from an empty buffer
  assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign evt_valid = (wr_ptr != rd_ptr);

  // Writes while full are ignored
  assign wr_en = push && !full;
  assign rd_en = evt_valid && evt_ready;

  // --------------------
  // Pointers
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= push_event;
    end
  end

  // Head of queue shown directly on the read port
  assign evt_out = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// File: kbd_event_pkg.sv
`default_nettype none

package kbd_event_pkg;

  // --------------------
  // Hub geometry
  // --------------------

  // Keyboard channels feeding the arbiter
  localparam int unsigned NUM_CHANNELS = 2;

  // --------------------
  // Key event word
  // --------------------

  // One folded key event, 11 bits
  typedef struct packed {
    logic       port;
    logic       released;
    logic       extended;
    logic [7:0] code;
  } kbd_event_t;

endpackage

`default_nettype wire

// File: kbd_hub.sv
`timescale 1ns/1ns
`default_nettype none

module kbd_hub
  import kbd_event_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH   = 8,
  parameter int unsigned STALL_CYCLES = 2000
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [NUM_CHANNELS-1:0] ps2_clk,
  input  logic [NUM_CHANNELS-1:0] ps2_data,
  input  logic                    evt_ready,
  output logic                    evt_valid,
  output logic                    evt_port,
  output logic                    evt_released,
  output logic                    evt_extended,
  output logic [7:0]              evt_code,
  output logic [NUM_CHANNELS-1:0] overflow
);

  logic       frame_valid0;
  logic       frame_valid1;
  logic [7:0] frame_data0;
  logic [7:0] frame_data1;
  logic       push;
  logic       full;
  kbd_event_t push_event;
  kbd_event_t evt_out;

  key_event_if chan0_if ();
  key_event_if chan1_if ();

  // --------------------
  // Channel 0
  // --------------------

  ps2_rx #(.STALL_CYCLES(STALL_CYCLES)) rx0_inst (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk[0]),
    .ps2_data    (ps2_data[0]),
    .frame_valid (frame_valid0),
    .frame_data  (frame_data0)
  );

  key_event_decoder dec0_inst (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid0),
    .frame_data  (frame_data0),
    .evt         (chan0_if.offer),
    .overflow    (overflow[0])
  );

  // --------------------
  // Channel 1
  // --------------------

  ps2_rx #(.STALL_CYCLES(STALL_CYCLES)) rx1_inst (
    .clk         (clk),
    .rst         (rst),
    .ps2_clk     (ps2_clk[1]),
    .ps2_data    (ps2_data[1]),
    .frame_valid (frame_valid1),
    .frame_data  (frame_data1)
  );

  key_event_decoder dec1_inst (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid1),
    .frame_data  (frame_data1),
    .evt         (chan1_if.offer),
    .overflow    (overflow[1])
  );

  // --------------------
  // Shared arbiter and FIFO
  // --------------------

  event_arbiter arb_inst (
    .clk        (clk),
    .rst        (rst),
    .full       (full),
    .chan0      (chan0_if.grant),
    .chan1      (chan1_if.grant),
    .push       (push),
    .push_event (push_event)
  );

  event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_inst (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_event (push_event),
    .evt_ready  (evt_ready),
    .full       (full),
    .evt_valid  (evt_valid),
    .evt_out    (evt_out)
  );

  // Host read port fields
  assign evt_port     = evt_out.port;
  assign evt_released = evt_out.released;
  assign evt_extended = evt_out.extended;
  assign evt_code     = evt_out.code;

endmodule

`default_nettype wire

// File: key_event_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_event_decoder
  import ps2_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        frame_valid,
  input  logic [7:0]  frame_data,
  key_event_if.offer  evt,
  output logic        overflow
);

  logic       ext_flag;
  logic       brk_flag;
  logic       req_q;
  logic       rel_q;
  logic       ext_q;
  logic [7:0] code_q;
  logic       is_ext;
  logic       is_brk;
  logic       is_code;
  logic       busy;

  // --------------------
  // Byte classification
  // --------------------

  assign is_ext  = frame_valid && (frame_data == PS2_PREFIX_EXT);
  assign is_brk  = frame_valid && (frame_data == PS2_PREFIX_BREAK);
  assign is_code = frame_valid && !is_ext && !is_brk;

  // Handshake still in flight until ack has dropped
  assign busy = req_q | evt.ack;

  // --------------------
  // Prefix flags and offer
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ext_flag <= 1'b0;
      brk_flag <= 1'b0;
      req_q    <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (is_ext) begin
        ext_flag <= 1'b1;
      end
      if (is_brk) begin
        brk_flag <= 1'b1;
      end
      // Any scan code ends the prefix run, even a dropped one
      if (is_code) begin
        ext_flag <= 1'b0;
        brk_flag <= 1'b0;
      end

      // Phase 1 on a new code, phase 3 once ack is seen
      if (is_code && !busy) begin
        req_q <= 1'b1;
      end else if (req_q && evt.ack) begin
        req_q <= 1'b0;
      end

      // Sticky until reset
      if (is_code && busy) begin
        overflow <= 1'b1;
      end
    end
  end

  // Pending event fields, frozen while req is high
  always_ff @(posedge clk) begin
    if (is_code && !busy) begin
      rel_q  <= brk_flag;
      ext_q  <= ext_flag;
      code_q <= frame_data;
    end
  end

  assign evt.req      = req_q;
  assign evt.released = rel_q;
  assign evt.extended = ext_q;
  assign evt.code     = code_q;

endmodule

`default_nettype wire

// File: key_event_if.sv
`timescale 1ns/1ns
`default_nettype none

// One channel's event offer with four-phase req/ack
interface key_event_if;

  logic       req;
  logic       ack;
  // Event fields, held stable while req is high
  logic       released;
  logic       extended;
  logic [7:0] code;

  // Decoder side
  modport offer (output req, output released, output extended, output code, input ack);

  // Arbiter side
  modport grant (input req, input released, input extended, input code, output ack);

endinterface

`default_nettype wire

// File: project.f
ps2_pkg.sv
kbd_event_pkg.sv
key_event_if.sv
ps2_rx.sv
key_event_decoder.sv
event_arbiter.sv
event_fifo.sv
kbd_hub.sv
tb_kbd_hub.sv

// File: ps2_pkg.sv
`default_nettype none

package ps2_pkg;

  // --------------------
  // Frame layout
  // --------------------

  // Data bits between start and parity, sent LSB first
  localparam int unsigned PS2_DATA_BITS = 8;

  // Receiver FSM states
  typedef enum logic [3:0] {
    PS2_IDLE   = 4'd0,
    PS2_DATA   = 4'd1,
    PS2_PARITY = 4'd2,
    PS2_STOP   = 4'd3
  } ps2_state_t;

  // --------------------
  // Scan code set 2 prefixes
  // --------------------

  // Extended key prefix
  localparam logic [7:0] PS2_PREFIX_EXT = 8'he0;
  // Break (key release) prefix
  localparam logic [7:0] PS2_PREFIX_BREAK = 8'hf0;

endpackage

`default_nettype wire

// File: ps2_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_rx
  import ps2_pkg::*;
#(
  parameter int unsigned STALL_CYCLES = 2000
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       frame_valid,
  output logic [7:0] frame_data
);

  localparam int unsigned STALL_W = $clog2(STALL_CYCLES);
  localparam int unsigned BIT_W   = $clog2(PS2_DATA_BITS);

  logic               clk_meta;
  logic               clk_sync;
  logic               clk_prev;
  logic               data_meta;
  logic               data_sync;
  logic               fall;
  ps2_state_t         state;
  logic [BIT_W-1:0]   bit_cnt;
  logic [7:0]         shreg;
  logic               parity_bit;
  logic [STALL_W-1:0] stall_cnt;
  logic               frame_ok;
  logic               stalled;

  // --------------------
  // Input synchronizers
  // --------------------

  // Idle PS/2 lines float high, so reset to 1 to avoid a false edge
  always_ff @(posedge clk) begin
    if (rst) begin
      clk_meta  <= 1'b1;
      clk_sync  <= 1'b1;
      clk_prev  <= 1'b1;
      data_meta <= 1'b1;
      data_sync <= 1'b1;
    end else begin
      clk_meta  <= ps2_clk;
      clk_sync  <= clk_meta;
      clk_prev  <= clk_sync;
      data_meta <= ps2_data;
      data_sync <= data_meta;
    end
  end

  // Falling edge of the synchronized device clock
  assign fall = clk_prev & ~clk_sync;

  // --------------------
  // Frame checks
  // --------------------

  // Odd parity over data plus parity bit, stop bit must be 1
  assign frame_ok = data_sync & (^{shreg, parity_bit});

  // No edge for too long inside a frame
  assign stalled = !fall && (state != PS2_IDLE) &&
                   (stall_cnt == STALL_W'(STALL_CYCLES - 1));

  // --------------------
  // Receiver FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= PS2_IDLE;
      bit_cnt     <= '0;
      stall_cnt   <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0;

      // Stall timer restarts on every edge and sits at zero when idle
      if (fall || state == PS2_IDLE) begin
        stall_cnt <= '0;
      end else begin
        stall_cnt <= stall_cnt + 1'b1;
      end

      case (state)
        PS2_IDLE: begin
          // Start bit must be 0, anything else is ignored
          if (fall && !data_sync) begin
            state   <= PS2_DATA;
            bit_cnt <= '0;
          end
        end
        PS2_DATA: begin
          if (fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(PS2_DATA_BITS - 1)) begin
              state <= PS2_PARITY;
            end
          end
        end
        PS2_PARITY: begin
          if (fall) begin
            state <= PS2_STOP;
          end
        end
        PS2_STOP: begin
          // Bad frames are dropped without notice
          if (fall) begin
            frame_valid <= frame_ok;
            state       <= PS2_IDLE;
          end
        end
        default: begin
          state <= PS2_IDLE;
        end
      endcase

      // Unplugged or glitching device, give up on the partial frame
      if (stalled) begin
        state <= PS2_IDLE;
      end
    end
  end

  // --------------------
  // Data path
  // --------------------

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (fall && state == PS2_DATA) begin
      shreg <= {data_sync, shreg[7:1]};
    end
    if (fall && state == PS2_PARITY) begin
      parity_bit <= data_sync;
    end
  end

  assign frame_data = shreg;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the kbd_hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_kbd_hub -f project.f -o tb_kbd_hub
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_kbd_hub > sim.log 2>&1
run_status=$?
cat sim.log

# The log decides pass or fail
if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0

// File: tb_kbd_hub.sv
`timescale 1ns/1ns
`default_nettype none

module tb_kbd_hub
  import kbd_event_pkg::*;
();

  // --------------------
  // Test constants
  // --------------------

  localparam int FIFO_DEPTH   = 8;
  localparam int STALL_CYCLES = 2000;
  localparam int CLK_PERIOD   = 4;
  // PS/2 half period in system clocks
  localparam int HALF_CLKS    = 20;
  localparam int FRAME_CLKS   = 11 * 2 * HALF_CLKS;
  // Frames per test with the stall gap in the bad frame test counted as five
  localparam int FRAME_COUNT  = 12 + 36 + 11 + 6 + 12;
  localparam int WATCHDOG_NS  = FRAME_COUNT * FRAME_CLKS * CLK_PERIOD * 2;
  localparam int DRAIN_CLKS   = FRAME_CLKS;

  // Scan code set 2 prefix bytes
  localparam logic [7:0] KEY_EXT   = 8'he0;
  localparam logic [7:0] KEY_BREAK = 8'hf0;

  // Frame kinds for the device driver
  localparam int MODE_GOOD       = 0;
  localparam int MODE_BAD_PARITY = 1;
  localparam int MODE_BAD_STOP   = 2;
  localparam int MODE_CUT        = 3;
  localparam int MODE_LOST       = 4;

  logic                    clk = 1'b0;
  logic                    rst = 1'b1;
  logic [NUM_CHANNELS-1:0] ps2_clk = 2'b11;
  logic [NUM_CHANNELS-1:0] ps2_data = 2'b11;
  logic                    evt_ready = 1'b1;
  logic                    evt_valid;
  logic                    evt_port;
  logic                    evt_released;
  logic                    evt_extended;
  logic [7:0]              evt_code;
  logic [NUM_CHANNELS-1:0] overflow;

  logic [31:0]             rng_state = 32'h3ff1_00d9;
  kbd_event_t              expected[$];
  // Prefix flags seen so far on each port
  logic [NUM_CHANNELS-1:0] ext_acc = '0;
  logic [NUM_CHANNELS-1:0] brk_acc = '0;
  // Match by port when both devices talk at once
  logic                    any_order = 1'b0;
  int                      received = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  kbd_hub #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .STALL_CYCLES (STALL_CYCLES)
  ) kbd_hub_inst (
    .clk          (clk),
    .rst          (rst),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .evt_ready    (evt_ready),
    .evt_valid    (evt_valid),
    .evt_port     (evt_port),
    .evt_released (evt_released),
    .evt_extended (evt_extended),
    .evt_code     (evt_code),
    .overflow     (overflow)
  );

  // --------------------
  // Helpers
  // --------------------

  task automatic fail_now(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  // xorshift32 step
  function automatic logic [31:0] rand_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Any byte except the two prefixes
  function automatic logic [7:0] random_code();
    logic [31:0] r;
    logic [7:0]  c;
    r = rand_next();
    c = r[7:0];
    if (c == KEY_EXT || c == KEY_BREAK) begin
      c = c ^ 8'h01;
    end
    return c;
  endfunction

  task automatic idle_gap();
    logic [31:0] r;
    r = rand_next();
    repeat (1 + int'(r[4:0])) @(posedge clk);
  endtask

  // Reference model fed at the stop bit's falling edge
  task automatic model_frame(input logic port, input logic [7:0] data, input int mode);
    kbd_event_t ev;
    if (mode == MODE_GOOD || mode == MODE_LOST) begin
      if (data == KEY_EXT) begin
        ext_acc[port] = 1'b1;
      end else if (data == KEY_BREAK) begin
        brk_acc[port] = 1'b1;
      end else begin
        // Lost codes still end the prefix run
        if (mode == MODE_GOOD) begin
          ev.port     = port;
          ev.released = brk_acc[port];
          ev.extended = ext_acc[port];
          ev.code     = data;
          expected.push_back(ev);
        end
        ext_acc[port] = 1'b0;
        brk_acc[port] = 1'b0;
      end
    end
  endtask

  // PS/2 device driver with data changing while the clock line is high
  task automatic send_frame(input logic port, input logic [7:0] data, input int mode);
    logic [10:0] bits;
    int          nbits;
    bits  = {1'b1, ~^data, data, 1'b0};
    nbits = 11;
    if (mode == MODE_BAD_PARITY) begin
      bits[9] = ^data;
    end
    if (mode == MODE_BAD_STOP) begin
      bits[10] = 1'b0;
    end
    if (mode == MODE_CUT) begin
      nbits = 4;
    end
    @(posedge clk);
    for (int i = 0; i < nbits; i++) begin
      ps2_data[port] <= bits[i];
      repeat (HALF_CLKS) @(posedge clk);
      ps2_clk[port] <= 1'b0;
      if (i == 10) begin
        model_frame(port, data, mode);
      end
      repeat (HALF_CLKS) @(posedge clk);
      ps2_clk[port] <= 1'b1;
    end
    // Release the data line
    ps2_data[port] <= 1'b1;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (expected.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > DRAIN_CLKS) begin
        fail_now($sformatf("%0d expected events never arrived", expected.size()));
      end
    end
  endtask

  // --------------------
  // Monitor
  // --------------------

  always @(posedge clk) begin
    kbd_event_t exp_evt;
    int         idx;
    if (!rst && evt_valid && evt_ready) begin
      if (expected.size() == 0) begin
        fail_now($sformatf("Unexpected event with code %0h from port %0d", evt_code, evt_port));
      end else begin
        idx = 0;
        // Oldest entry from the same port
        if (any_order) begin
          for (int i = expected.size() - 1; i >= 0; i--) begin
            if (expected[i].port == evt_port) begin
              idx = i;
            end
          end
        end
        exp_evt = expected[idx];
        expected.delete(idx);
        check_value("evt_port", 32'(evt_port), 32'(exp_evt.port));
        check_value("evt_released", 32'(evt_released), 32'(exp_evt.released));
        check_value("evt_extended", 32'(evt_extended), 32'(exp_evt.extended));
        check_value("evt_code", 32'(evt_code), 32'(exp_evt.code));
        received++;
      end
    end
  end

  // --------------------
  // Tests
  // --------------------

  task automatic stream_plain_codes(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_next();
      send_frame(r[9], random_code(), MODE_GOOD);
      idle_gap();
    end
    wait_drained();
  endtask

  // E0 then F0 in keyboard order with flags clearing after each code
  task automatic type_prefixed_keys(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_next();
      if (r[1]) begin
        send_frame(r[0], KEY_EXT, MODE_GOOD);
      end
      if (r[2]) begin
        send_frame(r[0], KEY_BREAK, MODE_GOOD);
      end
      send_frame(r[0], random_code(), MODE_GOOD);
      idle_gap();
    end
    wait_drained();
  endtask

  task automatic inject_bad_frames();
    // Prefix on port 1 must survive the bad frame after it
    send_frame(1'b1, KEY_EXT, MODE_GOOD);
    idle_gap();
    send_frame(1'b0, random_code(), MODE_BAD_PARITY);
    idle_gap();
    send_frame(1'b1, random_code(), MODE_BAD_STOP);
    idle_gap();
    send_frame(1'b0, random_code(), MODE_CUT);
    // Long enough for the stall timer to fire
    repeat (STALL_CYCLES + 100) @(posedge clk);
    send_frame(1'b0, random_code(), MODE_GOOD);
    idle_gap();
    send_frame(1'b1, random_code(), MODE_GOOD);
    wait_drained();
  endtask

  task automatic collide_frames(input int n);
    logic [31:0] r;
    logic [7:0]  c0;
    logic [7:0]  c1;
    any_order = 1'b1;
    for (int i = 0; i < n; i++) begin
      c0 = random_code();
      c1 = random_code();
      r  = rand_next();
      fork
        send_frame(1'b0, c0, MODE_GOOD);
        begin
          // Small skew that is sometimes zero
          repeat (int'(r[2:0])) @(posedge clk);
          send_frame(1'b1, c1, MODE_GOOD);
        end
      join
      idle_gap();
    end
    wait_drained();
    any_order = 1'b0;
  endtask

  task automatic overfill_fifo();
    @(posedge clk);
    evt_ready <= 1'b0;
    // Fill the FIFO so the last stored event comes from port 1
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_frame(1'(i), random_code(), MODE_GOOD);
      idle_gap();
    end
    // One pending offer per port
    send_frame(1'b0, random_code(), MODE_GOOD);
    idle_gap();
    send_frame(1'b1, random_code(), MODE_GOOD);
    idle_gap();
    @(negedge clk);
    check_value("evt_valid", 32'(evt_valid), 32'd1);
    check_value("overflow", 32'(overflow), 32'd0);
    // These find req still high and are dropped
    send_frame(1'b0, random_code(), MODE_LOST);
    idle_gap();
    send_frame(1'b1, random_code(), MODE_LOST);
    idle_gap();
    @(negedge clk);
    check_value("overflow", 32'(overflow), 32'd3);
    @(posedge clk);
    evt_ready <= 1'b1;
    wait_drained();
    repeat (20) @(posedge clk);
    @(negedge clk);
    check_value("evt_valid", 32'(evt_valid), 32'd0);
  endtask

  // --------------------
  // Main sequence and watchdog
  // --------------------

  initial begin
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(posedge clk);
    stream_plain_codes(12);
    type_prefixed_keys(12);
    inject_bad_frames();
    collide_frames(6);
    overfill_fifo();
    $display("Events checked: %0d", received);
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_now("Watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire
